/* include/cpu_config.svh */
// cpu sizes and opcode codes, included by the package and by every module that uses them
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_WORD_W   16  // data and instruction width
`define CPU_PC_W     7   // 128 program words
`define CPU_DADDR_W  8   // 256 data words
`define CPU_RADDR_W  4   // 16 registers

`define CPU_OP_NOOP  4'd0
`define CPU_OP_STORE 4'd1  // mem[addr] <= reg
`define CPU_OP_LOAD  4'd2  // reg <= mem[addr]
`define CPU_OP_ADD   4'd3
`define CPU_OP_SUB   4'd4
`define CPU_OP_HALT  4'd5

`endif

/* hw/cpu_pkg.sv */
// shared cpu types, imported with a wildcard import by every design module
`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0]  word_t;   // data or instruction word
  typedef logic [`CPU_PC_W-1:0]    pc_t;     // program address
  typedef logic [`CPU_DADDR_W-1:0] daddr_t;  // data memory address
  typedef logic [`CPU_RADDR_W-1:0] raddr_t;  // register index
  typedef logic                    alu_op_t; // 0 add, 1 subtract

  typedef enum logic [3:0] {
    INIT,
    FETCH,
    DECODE,
    EXEC_NOOP,
    EXEC_LOAD,
    EXEC_STORE,
    EXEC_ADD,
    EXEC_SUB,
    HALT
  } ctrl_state_t;

endpackage

/* hw/fetch_unit.sv */
// instruction fetch: loadable program memory, program counter and instruction register
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_unit import cpu_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  prog_wr,    // preload strobe, already gated by prog_sel
  input  pc_t   prog_addr,
  input  word_t prog_data,
  input  logic  pc_clr,
  input  logic  pc_inc,
  input  logic  ir_ld,
  output word_t instr       // ir content
);

  localparam int PROG_DEPTH = 2 ** `CPU_PC_W;

  word_t prog_mem [PROG_DEPTH];
  pc_t   pc;
  word_t ir;
  word_t prog_word;

  // preload only, the cpu never writes program memory
  always_ff @(posedge clk)
  begin
    if (prog_wr)
    begin
      prog_mem[prog_addr] <= prog_data;
    end
  end

  assign prog_word = prog_mem[pc];  // combinational read at pc

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc <= '0;
      ir <= '0;
    end
    else
    begin
      if (pc_clr)
      begin
        pc <= '0;
      end
      else if (pc_inc)
      begin
        pc <= pc + pc_t'(1);  // wraps at end of program memory
      end
      if (ir_ld)
      begin
        ir <= prog_word;
      end
    end
  end

  assign instr = ir;

endmodule

/* hw/controller.sv */
// fetch/decode/execute sequencer, turns the instruction register into control strobes
`timescale 1ns/1ps
`include "cpu_config.svh"

module controller import cpu_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    run,
  input  word_t   instr,
  output logic    pc_clr,
  output logic    pc_inc,
  output logic    ir_ld,
  output daddr_t  d_addr,
  output logic    d_wr,
  output raddr_t  ra_addr,
  output raddr_t  rb_addr,
  output raddr_t  rf_waddr,
  output logic    rf_wr,
  output logic    rf_sel,   // 1 selects memory data
  output alu_op_t alu_op,
  output logic    halted
);

  ctrl_state_t state;
  ctrl_state_t next_state;
  logic [3:0]  opcode;

  assign opcode = instr[15:12];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= INIT;
    end
    else
    begin
      state <= next_state;
    end
  end

  always_comb
  begin
    next_state = state;
    pc_clr     = 1'b0;
    pc_inc     = 1'b0;
    ir_ld      = 1'b0;
    d_addr     = '0;
    d_wr       = 1'b0;
    ra_addr    = '0;
    rb_addr    = '0;
    rf_waddr   = '0;
    rf_wr      = 1'b0;
    rf_sel     = 1'b0;
    alu_op     = alu_op_t'(0);
    halted     = 1'b0;
    case (state)
      INIT:
      begin
        pc_clr = 1'b1;  // hold pc at zero until run
        if (run)
        begin
          next_state = FETCH;
        end
      end
      FETCH:
      begin
        ir_ld      = 1'b1;
        pc_inc     = 1'b1;
        next_state = DECODE;
      end
      DECODE:
      begin
        d_addr = instr[11:4];  // memory read starts here for load
        case (opcode)
          `CPU_OP_NOOP:  next_state = EXEC_NOOP;
          `CPU_OP_STORE: next_state = EXEC_STORE;
          `CPU_OP_LOAD:  next_state = EXEC_LOAD;
          `CPU_OP_ADD:   next_state = EXEC_ADD;
          `CPU_OP_SUB:   next_state = EXEC_SUB;
          `CPU_OP_HALT:  next_state = HALT;
          default:       next_state = EXEC_NOOP;  // undefined codes
        endcase
      end
      EXEC_LOAD:
      begin
        rf_waddr   = instr[3:0];
        rf_sel     = 1'b1;  // rdata valid this cycle
        rf_wr      = 1'b1;
        next_state = FETCH;
      end
      EXEC_STORE:
      begin
        d_addr     = instr[11:4];
        ra_addr    = instr[3:0];  // ra_data is the write data
        d_wr       = 1'b1;
        next_state = FETCH;
      end
      EXEC_ADD, EXEC_SUB:
      begin
        ra_addr    = instr[11:8];
        rb_addr    = instr[7:4];
        rf_waddr   = instr[3:0];
        rf_wr      = 1'b1;
        alu_op     = alu_op_t'(state == EXEC_SUB);
        next_state = FETCH;
      end
      HALT:
      begin
        halted = 1'b1;  // left only through reset
      end
      default:
      begin
        next_state = FETCH;  // EXEC_NOOP
      end
    endcase
  end

endmodule

/* hw/datapath.sv */
// register file with adder/subtracter and write-back select between memory and alu
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath import cpu_pkg::*; (
  input  logic    clk,
  input  raddr_t  ra_addr,
  input  raddr_t  rb_addr,
  input  raddr_t  rf_waddr,
  input  logic    rf_wr,
  input  logic    rf_sel,     // 1 memory data, 0 alu result
  input  alu_op_t alu_op,
  input  word_t   mem_rdata,
  output word_t   ra_data
);

  localparam int RF_DEPTH = 2 ** `CPU_RADDR_W;

  word_t rf [RF_DEPTH];
  word_t rb_data;
  word_t alu_result;
  word_t wb_data;

  // two combinational read ports
  assign ra_data = rf[ra_addr];
  assign rb_data = rf[rb_addr];

  // modulo 2^16, carry and borrow are dropped
  always_comb
  begin
    if (alu_op)
    begin
      alu_result = ra_data - rb_data;
    end
    else
    begin
      alu_result = ra_data + rb_data;
    end
  end

  assign wb_data = rf_sel ? mem_rdata : alu_result;

  always_ff @(posedge clk)
  begin
    if (rf_wr)
    begin
      rf[rf_waddr] <= wb_data;
    end
  end

endmodule

/* hw/data_memory.sv */
// 256-word data memory with registered read and a preload port used while the cpu is idle
`timescale 1ns/1ps
`include "cpu_config.svh"

module data_memory import cpu_pkg::*; (
  input  logic   clk,
  input  logic   prog_wr,
  input  daddr_t prog_addr,
  input  word_t  prog_data,
  input  logic   d_wr,
  input  daddr_t d_addr,
  input  word_t  wdata,
  output word_t  rdata      // valid the cycle after d_addr
);

  localparam int DATA_DEPTH = 2 ** `CPU_DADDR_W;

  word_t mem [DATA_DEPTH];

  always_ff @(posedge clk)
  begin
    if (prog_wr)
    begin
      mem[prog_addr] <= prog_data;  // preload wins
    end
    else if (d_wr)
    begin
      mem[d_addr] <= wdata;
    end
    rdata <= mem[d_addr];
  end

endmodule

/* hw/cpu_top.sv */
// cpu top level: fetch, control, datapath and data memory with preload and store outputs
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top import cpu_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   run,
  input  logic   prog_wr,
  input  logic   prog_sel,     // 0 program memory, 1 data memory
  input  word_t  prog_addr,
  input  word_t  prog_data,
  output logic   store_valid,
  output daddr_t store_addr,
  output word_t  store_data,
  output logic   halted
);

  word_t   instr;
  logic    pc_clr;
  logic    pc_inc;
  logic    ir_ld;
  daddr_t  d_addr;
  logic    d_wr;
  raddr_t  ra_addr;
  raddr_t  rb_addr;
  raddr_t  rf_waddr;
  logic    rf_wr;
  logic    rf_sel;
  alu_op_t alu_op;
  word_t   ra_data;
  word_t   mem_rdata;

  fetch_unit i_fetch (
    .clk       (clk),
    .arst_n    (arst_n),
    .prog_wr   (prog_wr & ~prog_sel),
    .prog_addr (prog_addr[`CPU_PC_W-1:0]),
    .prog_data (prog_data),
    .pc_clr    (pc_clr),
    .pc_inc    (pc_inc),
    .ir_ld     (ir_ld),
    .instr     (instr)
  );

  controller i_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .run      (run),
    .instr    (instr),
    .pc_clr   (pc_clr),
    .pc_inc   (pc_inc),
    .ir_ld    (ir_ld),
    .d_addr   (d_addr),
    .d_wr     (d_wr),
    .ra_addr  (ra_addr),
    .rb_addr  (rb_addr),
    .rf_waddr (rf_waddr),
    .rf_wr    (rf_wr),
    .rf_sel   (rf_sel),
    .alu_op   (alu_op),
    .halted   (halted)
  );

  datapath i_dpath (
    .clk       (clk),
    .ra_addr   (ra_addr),
    .rb_addr   (rb_addr),
    .rf_waddr  (rf_waddr),
    .rf_wr     (rf_wr),
    .rf_sel    (rf_sel),
    .alu_op    (alu_op),
    .mem_rdata (mem_rdata),
    .ra_data   (ra_data)
  );

  data_memory i_dmem (
    .clk       (clk),
    .prog_wr   (prog_wr & prog_sel),
    .prog_addr (prog_addr[`CPU_DADDR_W-1:0]),
    .prog_data (prog_data),
    .d_wr      (d_wr),
    .d_addr    (d_addr),
    .wdata     (ra_data),
    .rdata     (mem_rdata)
  );

  // the store stream is the data memory write port seen from outside
  assign store_valid = d_wr;
  assign store_addr  = d_addr;
  assign store_data  = ra_data;

endmodule

/* testbench/tb_cpu_top.sv */
// cpu_top testbench that preloads both memories from the pattern file and checks stores
`timescale 1ns/1ps

module tb_cpu_top import cpu_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int RUN_TIMEOUT  = 2000;  // cycles until halted
  localparam int HALT_HOLD    = 50;

  logic   clk;
  logic   arst_n;
  logic   run;
  logic   prog_wr;
  logic   prog_sel;
  word_t  prog_addr;
  word_t  prog_data;
  logic   store_valid;
  daddr_t store_addr;
  word_t  store_data;
  logic   halted;

  logic   pre_sel [$];  // 0 program, 1 data
  word_t  pre_addr [$];
  word_t  pre_data [$];
  daddr_t exp_addr [$];
  word_t  exp_data [$];
  int     store_count;

  cpu_top i_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .run         (run),
    .prog_wr     (prog_wr),
    .prog_sel    (prog_sel),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data),
    .halted      (halted)
  );

  always #20 clk = ~clk;

  task automatic stop_on_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "value check failed");
  endtask

  task automatic stop_on_error(input string msg);
    $display("ERROR: %s", msg);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  task automatic read_patterns();
    int    fd;
    int    n;
    string line;
    byte   kind;
    word_t a;
    word_t d;
    fd = $fopen("testbench/cpu_patterns.txt", "r");
    if (fd == 0)
    begin
      stop_on_error("could not open the pattern file testbench/cpu_patterns.txt");
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 2 && line.getc(0) != "#")
      begin
        kind = line.getc(0);
        n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, d);
        if (n != 2)
        begin
          stop_on_error($sformatf("malformed pattern line: %s", line));
        end
        case (kind)
          "I":
          begin
            pre_sel.push_back(1'b0);
            pre_addr.push_back(a);
            pre_data.push_back(d);
          end
          "D":
          begin
            pre_sel.push_back(1'b1);
            pre_addr.push_back(a);
            pre_data.push_back(d);
          end
          "E":
          begin
            exp_addr.push_back(daddr_t'(a));
            exp_data.push_back(d);
          end
          default: stop_on_error($sformatf("unknown record type in line: %s", line));
        endcase
      end
    end
    $fclose(fd);
  endtask

  // nothing may come out of the cpu before run
  task automatic check_idle();
    assert (!store_valid && !halted)
    else stop_on_mismatch("store_valid or halted high before run");
  endtask

  task automatic check_store();
    if (store_valid)
    begin
      assert (store_count < exp_addr.size())
      else stop_on_mismatch($sformatf("unexpected store addr %02h data %04h",
                                      store_addr, store_data));
      assert (store_addr == exp_addr[store_count] && store_data == exp_data[store_count])
      else stop_on_mismatch($sformatf("store %0d got addr %02h data %04h, expected %02h %04h",
                                      store_count, store_addr, store_data,
                                      exp_addr[store_count], exp_data[store_count]));
      store_count++;
    end
  endtask

  initial
  begin
    int cycles;
    int idx;
    clk         = 1'b0;
    arst_n      = 1'b0;
    run         = 1'b0;
    prog_wr     = 1'b0;
    prog_sel    = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    store_count = 0;
    read_patterns();

    for (cycles = 0; cycles < RESET_CYCLES; cycles++)
    begin
      @(negedge clk);
      check_idle();
    end
    arst_n = 1'b1;

    // one preload word per cycle
    for (idx = 0; idx < pre_sel.size(); idx++)
    begin
      @(negedge clk);
      check_idle();
      prog_wr   = 1'b1;
      prog_sel  = pre_sel[idx];
      prog_addr = pre_addr[idx];
      prog_data = pre_data[idx];
    end
    @(negedge clk);
    check_idle();
    prog_wr = 1'b0;
    run     = 1'b1;

    cycles = 0;
    while (!halted && cycles < RUN_TIMEOUT)
    begin
      @(negedge clk);
      check_store();
      cycles++;
    end
    if (!halted)
    begin
      stop_on_error($sformatf("timeout, halted did not rise within %0d cycles", RUN_TIMEOUT));
    end

    // halted must hold and the words after HALT must stay dead
    for (cycles = 0; cycles < HALT_HOLD; cycles++)
    begin
      @(negedge clk);
      assert (halted)
      else stop_on_mismatch("halted dropped after HALT");
      assert (!store_valid)
      else stop_on_mismatch($sformatf("store after HALT to addr %02h", store_addr));
    end

    assert (store_count == exp_addr.size())
    begin
      $display("All tests passed!");
      $finish;
    end
    else
    begin
      stop_on_mismatch($sformatf("saw %0d stores, expected %0d", store_count,
                                 exp_addr.size()));
    end
  end

endmodule

/* src.f */
+incdir+include
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/controller.sv
hw/datapath.sv
hw/data_memory.sv
hw/cpu_top.sv
testbench/tb_cpu_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --assert --timescale 1ns/1ps
TOP       ?= tb_cpu_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "simulation PASSED" || (echo "simulation FAILED"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/cpu_patterns.txt */
# record  hex_a  hex_b   I: program address, instruction   D: data address, word
#                        E: expected store address, store data, in store order
D 10 1234
D 11 ffff
D 12 0001
D 13 0005
D 14 0007
I 00 2101  load r1 <- [10]
I 01 1201  store [20] <- r1
I 02 2112  load r2 <- [11]
I 03 2123  load r3 <- [12]
I 04 3234  add r4 = r2 + r3, carry out
I 05 1214  store [21] <- r4
I 06 2135  load r5 <- [13]
I 07 2146  load r6 <- [14]
I 08 4567  sub r7 = r5 - r6, negative
I 09 1227  store [22] <- r7
I 0a 0111  noop
I 0b 6111  undefined opcodes 6 to f
I 0c 7111
I 0d 8111
I 0e 9111
I 0f a111
I 10 b111
I 11 c111
I 12 d111
I 13 e111
I 14 f111
I 15 1231  store [23] <- r1, untouched
I 16 5000  halt
I 17 1241  never executed
I 18 3111  never executed
E 20 1234
E 21 0000
E 22 fffe
E 23 1234
